// ==== rtl/dma_defines.svh ====
// ------------------------------------------------
// widths, scratch memory depth and
// apb register offsets of the copy engine
// ------------------------------------------------
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_ADDR_W       8
`define DMA_WORD_W       32
`define DMA_STRB_W       4
`define DMA_MEM_DEPTH    64
`define DMA_LEN_W        9
`define DMA_APB_ADDR_W   8
`define DMA_APB_DATA_W   32

// register map, byte offsets on apb
`define DMA_REG_CTRL     8'h00
`define DMA_REG_STATUS   8'h04
`define DMA_REG_SRC      8'h08
`define DMA_REG_DST      8'h0C
`define DMA_REG_LEN      8'h10
`define DMA_REG_MEM_ADDR 8'h14
`define DMA_REG_MEM_DATA 8'h18

`endif

// ==== rtl/dma_reg_pkg.sv ====
// ------------------------------------------------
// register map and transfer configuration types
// ------------------------------------------------
`default_nettype none

`include "dma_defines.svh"

package dma_reg_pkg;

    // scratch byte address, wraps modulo 256
    typedef logic [`DMA_ADDR_W-1:0] byte_addr_t;

    // transfer length in bytes, 0 to 256
    typedef logic [`DMA_LEN_W-1:0] xfer_len_t;

    // addressing mode, chosen per side
    typedef enum logic {
        BURST_INCR  = 1'b0,
        BURST_FIXED = 1'b1
    } burst_e;

    typedef logic [`DMA_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`DMA_APB_DATA_W-1:0] apb_data_t;

endpackage

`default_nettype wire

// ==== rtl/dma_mem_pkg.sv ====
// ------------------------------------------------
// scratch memory word, strobe and index types
// ------------------------------------------------
`default_nettype none

`include "dma_defines.svh"

package dma_mem_pkg;

    typedef logic [`DMA_WORD_W-1:0] mem_word_t;
    typedef logic [`DMA_STRB_W-1:0] mem_strb_t;

    // word index into the array
    typedef logic [$clog2(`DMA_MEM_DEPTH)-1:0] word_idx_t;

    // byte position inside one word
    typedef logic [$clog2(`DMA_STRB_W)-1:0] byte_lane_t;

endpackage

`default_nettype wire

// ==== rtl/dma_ifs.sv ====
// ------------------------------------------------
// dma_cfg_if  transfer setup and status
// dma_mem_if  one scratch memory port
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface dma_cfg_if;
    import dma_reg_pkg::*;

    byte_addr_t src;
    byte_addr_t dst;
    xfer_len_t  len;
    burst_e     src_burst;
    burst_e     dst_burst;
    // single cycle pulse
    logic       start;
    logic       busy;
    logic       done_pulse;

    modport regs (output src, dst, len, src_burst, dst_burst, start,
                  input  busy, done_pulse);
    modport engine (input  src, dst, len, src_burst, dst_burst, start,
                    output busy, done_pulse);
endinterface

interface dma_mem_if;
    import dma_mem_pkg::*;

    logic      rd_en;
    word_idx_t rd_idx;
    // valid one cycle after rd_en
    mem_word_t rd_data;
    logic      wr_en;
    word_idx_t wr_idx;
    mem_word_t wr_data;
    mem_strb_t wr_strb;

    modport requester (output rd_en, rd_idx, wr_en, wr_idx, wr_data, wr_strb,
                       input  rd_data);
    modport memory (input  rd_en, rd_idx, wr_en, wr_idx, wr_data, wr_strb,
                    output rd_data);
endinterface

`default_nettype wire

// ==== rtl/dma_regs.sv ====
// ------------------------------------------------
// apb slave with the dma configuration registers,
// sticky done status and the scratch memory window
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_regs (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  dma_reg_pkg::apb_addr_t paddr_i,
    input  dma_reg_pkg::apb_data_t pwdata_i,
    output dma_reg_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   irq_done_o,
    dma_cfg_if.regs                cfg_o,
    dma_mem_if.requester           mem_o
);
    import dma_reg_pkg::*;
    import dma_mem_pkg::*;

    byte_addr_t src_q;
    byte_addr_t dst_q;
    xfer_len_t  len_q;
    burst_e     src_burst_q;
    burst_e     dst_burst_q;
    word_idx_t  mem_addr_q;
    logic       start_q;
    logic       done_q;
    logic       rd_wait_q;
    logic       access;
    logic       wr_access;
    logic       sel_mem_data;
    logic       mem_rd_issue;

    // ------------------------------------------------
    // apb decode
    // ------------------------------------------------
    assign access       = psel_i & penable_i;
    assign wr_access    = access & pwrite_i;
    assign sel_mem_data = (paddr_i == `DMA_REG_MEM_DATA);
    // first access cycle of a window read, the second one returns data
    assign mem_rd_issue = access & ~pwrite_i & sel_mem_data & ~cfg_o.busy & ~rd_wait_q;

    assign pready_o  = access & (pwrite_i | ~sel_mem_data | cfg_o.busy | rd_wait_q);
    assign pslverr_o = access & sel_mem_data & cfg_o.busy;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q       <= '0;
            dst_q       <= '0;
            len_q       <= '0;
            src_burst_q <= BURST_INCR;
            dst_burst_q <= BURST_INCR;
            mem_addr_q  <= '0;
            start_q     <= 1'b0;
            done_q      <= 1'b0;
            rd_wait_q   <= 1'b0;
        end else begin
            start_q   <= 1'b0;
            rd_wait_q <= mem_rd_issue;
            if (cfg_o.done_pulse) begin
                done_q <= 1'b1;
            end
            if (wr_access) begin
                case (paddr_i)
                    `DMA_REG_CTRL: begin
                        // whole write ignored while a copy runs
                        if (!cfg_o.busy) begin
                            src_burst_q <= burst_e'(pwdata_i[1]);
                            dst_burst_q <= burst_e'(pwdata_i[2]);
                            if (pwdata_i[0]) begin
                                start_q <= 1'b1;
                                done_q  <= 1'b0;
                            end
                        end
                    end
                    `DMA_REG_SRC:      src_q      <= pwdata_i[$bits(byte_addr_t)-1:0];
                    `DMA_REG_DST:      dst_q      <= pwdata_i[$bits(byte_addr_t)-1:0];
                    `DMA_REG_LEN:      len_q      <= pwdata_i[$bits(xfer_len_t)-1:0];
                    `DMA_REG_MEM_ADDR: mem_addr_q <= pwdata_i[$bits(word_idx_t)-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read mux, unmapped offsets read as zero
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `DMA_REG_CTRL:     prdata_o = apb_data_t'({dst_burst_q, src_burst_q, 1'b0});
            `DMA_REG_STATUS:   prdata_o = apb_data_t'({done_q, cfg_o.busy});
            `DMA_REG_SRC:      prdata_o = apb_data_t'(src_q);
            `DMA_REG_DST:      prdata_o = apb_data_t'(dst_q);
            `DMA_REG_LEN:      prdata_o = apb_data_t'(len_q);
            `DMA_REG_MEM_ADDR: prdata_o = apb_data_t'(mem_addr_q);
            `DMA_REG_MEM_DATA: prdata_o = apb_data_t'(mem_o.rd_data);
            default: ;
        endcase
    end

    // ------------------------------------------------
    // outputs to engine and memory window
    // ------------------------------------------------
    assign cfg_o.src       = src_q;
    assign cfg_o.dst       = dst_q;
    assign cfg_o.len       = len_q;
    assign cfg_o.src_burst = src_burst_q;
    assign cfg_o.dst_burst = dst_burst_q;
    assign cfg_o.start     = start_q;
    assign irq_done_o      = done_q;

    // MEM_ADDR holds a word index, whole words only
    assign mem_o.rd_en   = mem_rd_issue;
    assign mem_o.rd_idx  = mem_addr_q;
    assign mem_o.wr_en   = wr_access & sel_mem_data & ~cfg_o.busy;
    assign mem_o.wr_idx  = mem_addr_q;
    assign mem_o.wr_data = mem_word_t'(pwdata_i);
    assign mem_o.wr_strb = '1;

endmodule

`default_nettype wire

// ==== rtl/dma_copy_engine.sv ====
// ------------------------------------------------
// byte copy engine, one byte per cycle
// stage 1 reads the source word, stage 2 writes
// the byte into its destination lane
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dma_copy_engine (
    input  logic         clk,
    input  logic         rst_n_i,
    dma_cfg_if.engine    cfg_i,
    dma_mem_if.requester mem_o
);
    import dma_reg_pkg::*;
    import dma_mem_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e     state_q;
    xfer_len_t  count_q;
    byte_addr_t src_ptr_q;
    byte_addr_t dst_ptr_q;
    logic       s2_valid_q;
    word_idx_t  s2_dst_idx_q;
    byte_lane_t s2_dst_lane_q;
    byte_lane_t s2_src_lane_q;
    logic       running;
    logic       issue;
    logic [7:0] s2_byte;

    assign running = (state_q == RUN);
    // a byte is read in every run cycle but the last
    assign issue   = running & (count_q != '0);

    // ------------------------------------------------
    // control fsm
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            count_q    <= '0;
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= issue;
            case (state_q)
                IDLE: begin
                    if (cfg_i.start) begin
                        state_q <= RUN;
                        count_q <= cfg_i.len;
                    end
                end
                RUN: begin
                    if (issue) begin
                        count_q <= count_q - 1'b1;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // pointers, fixed sides hold their address
    always_ff @(posedge clk) begin
        if (!running && cfg_i.start) begin
            src_ptr_q <= cfg_i.src;
            dst_ptr_q <= cfg_i.dst;
        end else if (issue) begin
            if (cfg_i.src_burst == BURST_INCR) begin
                src_ptr_q <= src_ptr_q + 1'b1;
            end
            if (cfg_i.dst_burst == BURST_INCR) begin
                dst_ptr_q <= dst_ptr_q + 1'b1;
            end
        end
        if (issue) begin
            s2_dst_idx_q  <= dst_ptr_q[$bits(byte_addr_t)-1:$bits(byte_lane_t)];
            s2_dst_lane_q <= dst_ptr_q[$bits(byte_lane_t)-1:0];
            s2_src_lane_q <= src_ptr_q[$bits(byte_lane_t)-1:0];
        end
    end

    // ------------------------------------------------
    // memory port
    // ------------------------------------------------
    assign mem_o.rd_en  = issue;
    assign mem_o.rd_idx = src_ptr_q[$bits(byte_addr_t)-1:$bits(byte_lane_t)];

    // move the source byte from its lane into the destination lane
    assign s2_byte       = mem_o.rd_data[{s2_src_lane_q, 3'b000} +: 8];
    assign mem_o.wr_en   = s2_valid_q;
    assign mem_o.wr_idx  = s2_dst_idx_q;
    assign mem_o.wr_data = mem_word_t'(s2_byte) << {s2_dst_lane_q, 3'b000};
    assign mem_o.wr_strb = mem_strb_t'(1) << s2_dst_lane_q;

    assign cfg_i.busy       = running;
    assign cfg_i.done_pulse = running & (count_q == '0);

endmodule

`default_nettype wire

// ==== rtl/dma_scratch_mem.sv ====
// ------------------------------------------------
// scratch word memory with byte lanes, engine and
// host ports, registered write-first read data
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_scratch_mem (
    input  logic      clk,
    dma_mem_if.memory eng_i,
    dma_mem_if.memory host_i
);
    import dma_mem_pkg::*;

    mem_word_t mem_q [`DMA_MEM_DEPTH];
    mem_word_t rd_q;
    logic      rd_en;
    logic      wr_en;
    word_idx_t rd_idx;
    word_idx_t wr_idx;
    mem_word_t wr_data;
    mem_strb_t wr_strb;

    // engine port wins, host only runs while the engine is idle
    assign rd_en   = eng_i.rd_en | host_i.rd_en;
    assign rd_idx  = eng_i.rd_en ? eng_i.rd_idx : host_i.rd_idx;
    assign wr_en   = eng_i.wr_en | host_i.wr_en;
    assign wr_idx  = eng_i.wr_en ? eng_i.wr_idx : host_i.wr_idx;
    assign wr_data = eng_i.wr_en ? eng_i.wr_data : host_i.wr_data;
    assign wr_strb = eng_i.wr_en ? eng_i.wr_strb : host_i.wr_strb;

    always_ff @(posedge clk) begin
        for (int l = 0; l < `DMA_STRB_W; l++) begin
            if (wr_en && wr_strb[l]) begin
                mem_q[wr_idx][l*8 +: 8] <= wr_data[l*8 +: 8];
            end
            // same word written this cycle, pass new bytes through
            if (rd_en) begin
                if (wr_en && wr_strb[l] && (wr_idx == rd_idx)) begin
                    rd_q[l*8 +: 8] <= wr_data[l*8 +: 8];
                end else begin
                    rd_q[l*8 +: 8] <= mem_q[rd_idx][l*8 +: 8];
                end
            end
        end
    end

    assign eng_i.rd_data  = rd_q;
    assign host_i.rd_data = rd_q;

endmodule

`default_nettype wire

// ==== rtl/dma_top.sv ====
// ------------------------------------------------
// dma top level, apb slave port and done irq
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dma_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  dma_reg_pkg::apb_addr_t paddr_i,
    input  dma_reg_pkg::apb_data_t pwdata_i,
    output dma_reg_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   irq_done_o
);

    dma_cfg_if cfg_if ();
    // host window port and engine port
    dma_mem_if host_mem_if ();
    dma_mem_if eng_mem_if ();

    dma_regs dma_regs_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .irq_done_o (irq_done_o),
        .cfg_o      (cfg_if.regs),
        .mem_o      (host_mem_if.requester)
    );

    dma_copy_engine dma_copy_engine_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .cfg_i   (cfg_if.engine),
        .mem_o   (eng_mem_if.requester)
    );

    dma_scratch_mem dma_scratch_mem_i (
        .clk    (clk),
        .eng_i  (eng_mem_if.memory),
        .host_i (host_mem_if.memory)
    );

endmodule

`default_nettype wire

// ==== sim/dma_props.sv ====
// ------------------------------------------------
// concurrent checks on the apb port, done irq and
// scratch memory writes, bound into dma_top
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_props (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  dma_reg_pkg::apb_addr_t paddr_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i,
    input  logic                   irq_done_i,
    input  logic                   busy_i,
    input  logic                   mem_wr_i
);
    int unsigned fail_count = 0;

    slverr_with_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        pslverr_i |-> pready_i)
        else begin
            $error("pslverr high without pready");
            fail_count = fail_count + 1;
        end

    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(irq_done_i && busy_i))
        else begin
            $error("done and busy high together");
            fail_count = fail_count + 1;
        end

    // window read has one wait state at most
    mem_read_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        (psel_i && penable_i && !pwrite_i && paddr_i == `DMA_REG_MEM_DATA)
        |-> ##[0:1] pready_i)
        else begin
            $error("memory window read took more than 2 cycles");
            fail_count = fail_count + 1;
        end

    write_source: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_wr_i |-> (busy_i || (psel_i && penable_i && pwrite_i)))
        else begin
            $error("memory write outside a copy or apb write");
            fail_count = fail_count + 1;
        end

endmodule

bind dma_top dma_props dma_props_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pready_i   (pready_o),
    .pslverr_i  (pslverr_o),
    .irq_done_i (irq_done_o),
    .busy_i     (cfg_if.busy),
    .mem_wr_i   (host_mem_if.wr_en | eng_mem_if.wr_en)
);

`default_nettype wire

// ==== sim/dma_tb.sv ====
// ------------------------------------------------
// testbench for the dma copy engine
// apb access tasks, shadow memory, reference copy,
// directed and random tests with a final report
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_tb;
    localparam int NUM_WORDS   = `DMA_MEM_DEPTH;
    localparam int RAND_COPIES = 6;
    localparam int NUM_COPIES  = RAND_COPIES + 6;
    // worst case cycles for one apb access and one sweep of all words
    localparam int ACCESS_CYC  = 5;
    localparam int SWEEP_CYC   = 2 * NUM_WORDS * ACCESS_CYC;
    localparam int COPY_CYC    = SWEEP_CYC + 10 * ACCESS_CYC + 260;
    localparam int TIMEOUT_CYC = 3 * SWEEP_CYC + NUM_COPIES * COPY_CYC + 200;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq_done;

    // byte image of the scratch memory
    logic [7:0]  shadow [256];
    integer      seed;
    int          cycle_count;
    int          errors;
    int          checks;
    int          test_errors;
    string       test_name;

    dma_top dma_top_i (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .irq_done_o (irq_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------
    // apb master
    // ------------------------------------------------
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // transfer ends on the rising edge after pready is seen
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Fail %s: expected %08h, actual %08h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s ok", test_name);
        end else begin
            $display("%s had %0d mismatches", test_name, test_errors);
        end
    endtask

    // ------------------------------------------------
    // reference model
    // ------------------------------------------------
    // sequential byte loop where a fixed side keeps its address
    function automatic void copy_ref(input logic [7:0] src, input logic [7:0] dst,
                                     input int len, input logic src_fixed,
                                     input logic dst_fixed);
        logic [7:0] s;
        logic [7:0] d;
        s = src;
        d = dst;
        for (int i = 0; i < len; i++) begin
            shadow[d] = shadow[s];
            if (!src_fixed) begin
                s = s + 8'd1;
            end
            if (!dst_fixed) begin
                d = d + 8'd1;
            end
        end
    endfunction

    // lane 0 is the lowest byte address
    function automatic logic [31:0] shadow_word(input logic [5:0] idx);
        return {shadow[{idx, 2'd3}], shadow[{idx, 2'd2}],
                shadow[{idx, 2'd1}], shadow[{idx, 2'd0}]};
    endfunction

    task automatic load_memory();
        logic [31:0] word;
        for (int w = 0; w < NUM_WORDS; w++) begin
            word = $random(seed);
            apb_write(`DMA_REG_MEM_ADDR, 32'(w));
            apb_write(`DMA_REG_MEM_DATA, word);
            for (int l = 0; l < 4; l++) begin
                shadow[8'(4 * w + l)] = 8'(word >> (8 * l));
            end
        end
    endtask

    task automatic compare_memory();
        logic [31:0] rdata;
        for (int w = 0; w < NUM_WORDS; w++) begin
            apb_write(`DMA_REG_MEM_ADDR, 32'(w));
            apb_read(`DMA_REG_MEM_DATA, rdata);
            check_value($sformatf("%s word %0d", test_name, w), shadow_word(6'(w)), rdata);
        end
    endtask

    task automatic start_copy(input logic [7:0] src, input logic [7:0] dst,
                              input logic [8:0] len, input logic src_fixed,
                              input logic dst_fixed);
        apb_write(`DMA_REG_SRC, 32'(src));
        apb_write(`DMA_REG_DST, 32'(dst));
        apb_write(`DMA_REG_LEN, 32'(len));
        apb_write(`DMA_REG_CTRL, {29'd0, dst_fixed, src_fixed, 1'b1});
    endtask

    // done is cleared by the accepted start
    task automatic wait_done();
        while (!irq_done) begin
            @(negedge clk);
        end
    endtask

    task automatic run_copy(input logic [7:0] src, input logic [7:0] dst,
                            input logic [8:0] len, input logic src_fixed,
                            input logic dst_fixed);
        start_copy(src, dst, len, src_fixed, dst_fixed);
        wait_done();
        copy_ref(src, dst, int'(len), src_fixed, dst_fixed);
        compare_memory();
    endtask

    // ------------------------------------------------
    // test sequence
    // ------------------------------------------------
    initial begin : main
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic        err;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        rst_n   = 1'b0;
        seed    = 32'h92c1;
        errors  = 0;
        checks  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("regs");
        apb_read(`DMA_REG_STATUS, rdata);
        check_value("regs status", 32'h0, rdata);
        rnd = $random(seed);
        apb_write(`DMA_REG_SRC, rnd);
        apb_write(`DMA_REG_DST, ~rnd);
        apb_write(`DMA_REG_LEN, rnd);
        apb_read(`DMA_REG_SRC, rdata);
        check_value("regs src", {24'd0, rnd[7:0]}, rdata);
        apb_read(`DMA_REG_DST, rdata);
        check_value("regs dst", {24'd0, ~rnd[7:0]}, rdata);
        apb_read(`DMA_REG_LEN, rdata);
        check_value("regs len", {23'd0, rnd[8:0]}, rdata);
        end_test();

        begin_test("mem_window");
        load_memory();
        compare_memory();
        end_test();

        begin_test("copy_incr");
        for (int i = 0; i < RAND_COPIES; i++) begin
            rnd = $random(seed);
            run_copy(rnd[7:0], rnd[15:8], {2'b00, rnd[22:16]} + 9'd1, 1'b0, 1'b0);
        end
        end_test();

        begin_test("copy_fixed");
        rnd = $random(seed);
        run_copy(rnd[7:0], rnd[15:8], 9'd40, 1'b1, 1'b0);
        run_copy(rnd[23:16], rnd[31:24], 9'd24, 1'b0, 1'b1);
        end_test();

        begin_test("overlap");
        // each byte reads the one written just before it
        run_copy(8'h40, 8'h41, 9'd60, 1'b0, 1'b0);
        run_copy(8'h83, 8'h80, 9'd60, 1'b0, 1'b0);
        end_test();

        begin_test("busy_len0");
        // word 30 lies outside the destination range of this copy
        apb_write(`DMA_REG_MEM_ADDR, 32'd30);
        start_copy(8'h10, 8'hA7, 9'd200, 1'b0, 1'b0);
        apb_access(1'b0, `DMA_REG_MEM_DATA, 32'h0, rdata, err);
        check_value("busy_len0 read slverr", 32'd1, {31'd0, err});
        apb_access(1'b1, `DMA_REG_MEM_DATA, 32'hDEADBEEF, rdata, err);
        check_value("busy_len0 write slverr", 32'd1, {31'd0, err});
        wait_done();
        copy_ref(8'h10, 8'hA7, 200, 1'b0, 1'b0);
        compare_memory();
        start_copy(8'h00, 8'h20, 9'd0, 1'b0, 1'b0);
        wait_done();
        apb_read(`DMA_REG_STATUS, rdata);
        check_value("busy_len0 status", 32'h2, rdata);
        compare_memory();
        end_test();

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dma_top_i.dma_props_i.fail_count);
        if (errors == 0 && dma_top_i.dma_props_i.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/dma_reg_pkg.sv
rtl/dma_mem_pkg.sv
rtl/dma_ifs.sv
rtl/dma_regs.sv
rtl/dma_copy_engine.sv
rtl/dma_scratch_mem.sv
rtl/dma_top.sv
sim/dma_props.sv
sim/dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
